//--- sources.f
+incdir+design
+incdir+verif
design/host_io_pkg.sv
design/host_addr_router.sv
design/host_device.sv
design/host_backing_mem.sv
design/host_io_top.sv
verif/host_io_tb.sv

//--- verif/host_io_tests.svh
/*
  Host I/O test tasks.
  Bus helpers for the command and response channel, and one
  directed test per behavior, each checking its own responses.
*/

`ifndef HOST_IO_TESTS_SVH
`define HOST_IO_TESTS_SVH

task automatic check_value(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
  assert (got === exp) pass_count++;
  else
  begin
    fail_count++;
    $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
  end
endtask

task automatic start_test();
  test_base = fail_count;
endtask

task automatic report_test(input string name);
  $display("%s done, %0d errors", name, fail_count - test_base);
endtask

// Holds the command until the edge that accepts it
task automatic send_cmd(input host_io_pkg::host_opcode_e op, input logic [31:0] addr,
                        input logic [63:0] data);
  logic ready_now;
  cmd.header.opcode = op;
  cmd.header.addr   = addr;
  cmd.header.size   = 2'd3;
  cmd.data          = data;
  cmd_v             = 1'b1;
  ready_now         = 1'b0;
  while (!ready_now)
  begin
    ready_now = cmd_ready;
    @(posedge clk);
    #1;
  end
  cmd_v = 1'b0;
endtask

// lat counts the edges waited until the response is taken
task automatic get_resp(output host_io_pkg::host_resp_s r, output int lat);
  lat = 0;
  while (!(resp_v && resp_ready))
  begin
    @(posedge clk);
    #1;
    lat++;
  end
  r = resp;
  @(posedge clk);
  #1;
endtask

task automatic access(input host_io_pkg::host_opcode_e op, input logic [31:0] addr,
                      input logic [63:0] data, output host_io_pkg::host_resp_s r);
  int lat;
  send_cmd(op, addr, data);
  get_resp(r, lat);
  check_value("resp latency", lat, 1);
  check_value("resp_o.header", r.header, cmd.header);
endtask

task automatic check_reset_state();
  start_test();
  check_value("finish_o", finish, 0);
  check_value("trace_en_o", trace_en, 0);
  check_value("putch_v_o", putch_v, 0);
  check_value("resp_v_o", resp_v, 0);
  check_value("cmd_ready_o", cmd_ready, 1);
  report_test("reset state");
endtask

task automatic mem_round_trip();
  logic [63:0]             model [`HOST_IO_MEM_WORDS];
  logic [31:0]             addrs [16];
  logic [31:0]             rnd;
  logic [63:0]             data;
  host_io_pkg::host_resp_s r;
  start_test();
  for (int i = 0; i < 16; i++)
  begin
    rnd      = $random(seed);
    // Low megabyte only, above the memory depth so indices wrap
    addrs[i] = {12'h000, rnd[19:3], 3'b000};
    data     = {$random(seed), $random(seed)};
    model[(addrs[i] >> 3) % `HOST_IO_MEM_WORDS] = data;
    access(host_io_pkg::e_host_wr, addrs[i], data, r);
    check_value("resp_o.err", r.err, 0);
    check_value("resp_o.data", r.data, 0);
  end
  for (int i = 0; i < 16; i++)
  begin
    access(host_io_pkg::e_host_rd, addrs[i], 64'h0, r);
    check_value("resp_o.err", r.err, 0);
    check_value("resp_o.data", r.data, model[(addrs[i] >> 3) % `HOST_IO_MEM_WORDS]);
  end
  report_test("memory round trip");
endtask

task automatic device_registers();
  logic [63:0]                   val;
  logic [`HOST_IO_NUM_TRACE-1:0] tv;
  host_io_pkg::host_resp_s       r;
  start_test();
  for (int i = 0; i < 3; i++)
  begin
    val = {$random(seed), $random(seed)};
    tv  = val[`HOST_IO_NUM_TRACE-1:0];
    access(host_io_pkg::e_host_wr, `HOST_IO_DEV_BASE + `HOST_IO_OFS_TRACE, val, r);
    check_value("resp_o.err", r.err, 0);
    check_value("trace_en_o", trace_en, tv);
    access(host_io_pkg::e_host_rd, `HOST_IO_DEV_BASE + `HOST_IO_OFS_TRACE, 64'h0, r);
    check_value("resp_o.data", r.data, 64'(tv));
  end
  // Upper bits of the data word carry junk that must be ignored
  access(host_io_pkg::e_host_wr, `HOST_IO_DEV_BASE + `HOST_IO_OFS_FINISH, 64'hF0 | 4'b0101, r);
  access(host_io_pkg::e_host_wr, `HOST_IO_DEV_BASE + `HOST_IO_OFS_FINISH, 64'hF0 | 4'b1000, r);
  check_value("finish_o", finish, 4'b1101);
  access(host_io_pkg::e_host_rd, `HOST_IO_DEV_BASE + `HOST_IO_OFS_FINISH, 64'h0, r);
  check_value("resp_o.data", r.data, 64'hD);
  access(host_io_pkg::e_host_rd, `HOST_IO_DEV_BASE + `HOST_IO_OFS_ID, 64'h0, r);
  check_value("resp_o.err", r.err, 0);
  check_value("resp_o.data", r.data, dev_id_lp);
  access(host_io_pkg::e_host_wr, `HOST_IO_DEV_BASE + `HOST_IO_OFS_ID, 64'hFFFF, r);
  check_value("resp_o.err", r.err, 1);
  check_value("finish_o", finish, 4'b1101);
  check_value("trace_en_o", trace_en, tv);
  access(host_io_pkg::e_host_rd, `HOST_IO_DEV_BASE + `HOST_IO_OFS_ID, 64'h0, r);
  check_value("resp_o.data", r.data, dev_id_lp);
  report_test("device registers");
endtask

task automatic putchar_strobe();
  host_io_pkg::host_resp_s r;
  int                      lat;
  start_test();
  check_value("putch_v_o", putch_v, 0);
  send_cmd(host_io_pkg::e_host_wr, `HOST_IO_DEV_BASE + `HOST_IO_OFS_PUTCH,
           64'h1234_5678_9abc_de41);
  check_value("putch_v_o", putch_v, 1);
  check_value("putch_o", putch, 8'h41);
  @(posedge clk);
  #1;
  check_value("putch_v_o", putch_v, 0);
  get_resp(r, lat);
  check_value("resp_o.err", r.err, 0);
  report_test("putchar");
endtask

task automatic back_pressure();
  logic [63:0]                   data;
  logic [`HOST_IO_NUM_TRACE-1:0] trace_before;
  host_io_pkg::host_resp_s       held;
  host_io_pkg::host_resp_s       r;
  start_test();
  data = {$random(seed), $random(seed)};
  access(host_io_pkg::e_host_wr, 32'h0000_0a08, data, r);
  trace_before = trace_en;
  resp_ready   = 1'b0;
  send_cmd(host_io_pkg::e_host_rd, 32'h0000_0a08, 64'h0);
  @(posedge clk);
  #1;
  check_value("resp_v_o", resp_v, 1);
  held = resp;
  check_value("resp_o.data", held.data, data);
  // A device write waits behind the stalled response
  cmd.header.opcode = host_io_pkg::e_host_wr;
  cmd.header.addr   = `HOST_IO_DEV_BASE + `HOST_IO_OFS_TRACE;
  cmd.data          = 64'h0000_0000_0000_0abc;
  cmd_v             = 1'b1;
  repeat (4)
  begin
    @(posedge clk);
    #1;
    check_value("resp_v_o", resp_v, 1);
    check_value("resp_o", resp, held);
    check_value("cmd_ready_o", cmd_ready, 0);
    check_value("trace_en_o", trace_en, trace_before);
  end
  resp_ready = 1'b1;
  @(posedge clk);
  #1;
  check_value("resp_v_o", resp_v, 0);
  check_value("cmd_ready_o", cmd_ready, 1);
  access(host_io_pkg::e_host_wr, `HOST_IO_DEV_BASE + `HOST_IO_OFS_TRACE,
         64'h0000_0000_0000_0abc, r);
  check_value("trace_en_o", trace_en, 12'habc);
  report_test("back-pressure");
endtask

task automatic error_responses();
  logic [63:0]                   data;
  logic [`HOST_IO_NUM_TRACE-1:0] trace_before;
  host_io_pkg::host_resp_s       r;
  start_test();
  data = {$random(seed), $random(seed)};
  access(host_io_pkg::e_host_wr, 32'h0000_0130, data, r);
  access(host_io_pkg::e_host_rsvd, 32'h0000_0130, ~data, r);
  check_value("resp_o.err", r.err, 1);
  access(host_io_pkg::e_host_rd, 32'h0000_0130, 64'h0, r);
  check_value("resp_o.err", r.err, 0);
  check_value("resp_o.data", r.data, data);
  trace_before = trace_en;
  access(host_io_pkg::e_host_rsvd, `HOST_IO_DEV_BASE + `HOST_IO_OFS_TRACE, 64'h555, r);
  check_value("resp_o.err", r.err, 1);
  check_value("trace_en_o", trace_en, trace_before);
  // Offset past the last device register
  access(host_io_pkg::e_host_wr, `HOST_IO_DEV_BASE + 32'h20, 64'h1, r);
  check_value("resp_o.err", r.err, 1);
  access(host_io_pkg::e_host_rd, `HOST_IO_DEV_BASE + `HOST_IO_OFS_TRACE, 64'h0, r);
  check_value("resp_o.data", r.data, 64'(trace_before));
  report_test("error responses");
endtask

`endif

//--- verif/host_io_tb.sv
/*
  Host I/O subsystem testbench.
  Clock, reset, the DUT, a cycle limit and the directed test
  sequence, closing with a summary of the check counts.
*/

`default_nettype none

`include "host_io_defines.svh"

module host_io_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [`HOST_IO_DATA_W-1:0] dev_id_lp = 64'h0000_0000_1357_9bdf;
  // All tests together take a few hundred cycles
  localparam int max_cycles_lp = 2000;

  logic                          clk;
  logic                          reset;
  host_io_pkg::host_cmd_s        cmd;
  logic                          cmd_v;
  logic                          cmd_ready;
  host_io_pkg::host_resp_s       resp;
  logic                          resp_v;
  logic                          resp_ready;
  logic [`HOST_IO_NUM_CORE-1:0]  finish;
  logic [`HOST_IO_NUM_TRACE-1:0] trace_en;
  logic [7:0]                    putch;
  logic                          putch_v;

  integer seed;
  int     pass_count;
  int     fail_count;
  int     test_base;
  int     cycle_count;

  initial
    clk = 1'b0;

  always #20 clk = ~clk;

  host_io_top #(.dev_id_p(dev_id_lp)) dut
    (
      .clk_i        (clk),
      .reset_i      (reset),
      .cmd_i        (cmd),
      .cmd_v_i      (cmd_v),
      .cmd_ready_o  (cmd_ready),
      .resp_o       (resp),
      .resp_v_o     (resp_v),
      .resp_ready_i (resp_ready),
      .finish_o     (finish),
      .trace_en_o   (trace_en),
      .putch_o      (putch),
      .putch_v_o    (putch_v)
    );

  initial
    cycle_count = 0;

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= max_cycles_lp)
    begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles_lp);
      $display("Test FAILED");
      $finish;
    end
  end

  `include "host_io_tests.svh"

  initial
  begin
    seed       = 36;
    pass_count = 0;
    fail_count = 0;
    test_base  = 0;
    reset      = 1'b1;
    cmd        = '0;
    cmd_v      = 1'b0;
    resp_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;

    check_reset_state();
    mem_round_trip();
    device_registers();
    putchar_strobe();
    back_pressure();
    error_responses();

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/host_io_top.sv
/*
  Host I/O subsystem top.
  Joins the address router to the host device and the backing
  memory behind one command and response channel.
*/

`default_nettype none

`include "host_io_defines.svh"

module host_io_top
  #(
    parameter logic [`HOST_IO_DATA_W-1:0] dev_id_p = 64'h0000_0000_0b0a_5e01
  )
  (
    input  logic                          clk_i,
    input  logic                          reset_i,

    input  host_io_pkg::host_cmd_s        cmd_i,
    input  logic                          cmd_v_i,
    output logic                          cmd_ready_o,

    output host_io_pkg::host_resp_s       resp_o,
    output logic                          resp_v_o,
    input  logic                          resp_ready_i,

    output logic [`HOST_IO_NUM_CORE-1:0]  finish_o,
    output logic [`HOST_IO_NUM_TRACE-1:0] trace_en_o,
    output logic [7:0]                    putch_o,
    output logic                          putch_v_o
  );

  host_io_pkg::host_cmd_s  dev_cmd;
  logic                    dev_cmd_v;
  host_io_pkg::host_resp_s dev_resp;
  logic                    dev_resp_v;
  logic                    dev_resp_yumi;

  host_io_pkg::host_cmd_s  mem_cmd;
  logic                    mem_cmd_v;
  host_io_pkg::host_resp_s mem_resp;
  logic                    mem_resp_v;
  logic                    mem_resp_yumi;

  host_addr_router router
    (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .cmd_i           (cmd_i),
      .cmd_v_i         (cmd_v_i),
      .cmd_ready_o     (cmd_ready_o),
      .resp_o          (resp_o),
      .resp_v_o        (resp_v_o),
      .resp_ready_i    (resp_ready_i),
      .dev_cmd_o       (dev_cmd),
      .dev_cmd_v_o     (dev_cmd_v),
      .dev_resp_i      (dev_resp),
      .dev_resp_v_i    (dev_resp_v),
      .dev_resp_yumi_o (dev_resp_yumi),
      .mem_cmd_o       (mem_cmd),
      .mem_cmd_v_o     (mem_cmd_v),
      .mem_resp_i      (mem_resp),
      .mem_resp_v_i    (mem_resp_v),
      .mem_resp_yumi_o (mem_resp_yumi)
    );

  host_device #(.dev_id_p(dev_id_p)) device
    (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cmd_i       (dev_cmd),
      .cmd_v_i     (dev_cmd_v),
      .resp_o      (dev_resp),
      .resp_v_o    (dev_resp_v),
      .resp_yumi_i (dev_resp_yumi),
      .finish_o    (finish_o),
      .trace_en_o  (trace_en_o),
      .putch_o     (putch_o),
      .putch_v_o   (putch_v_o)
    );

  host_backing_mem mem
    (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cmd_i       (mem_cmd),
      .cmd_v_i     (mem_cmd_v),
      .resp_o      (mem_resp),
      .resp_v_o    (mem_resp_v),
      .resp_yumi_i (mem_resp_yumi)
    );

endmodule

`default_nettype wire

//--- design/host_backing_mem.sv
/*
  Host backing memory.
  Word RAM serving full-doubleword reads and writes. The RAM is read
  on the accepting edge and the response is registered one cycle
  later, held until yumi.
*/

`default_nettype none

`include "host_io_defines.svh"

module host_backing_mem
  (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  host_io_pkg::host_cmd_s  cmd_i,
    input  logic                    cmd_v_i,

    output host_io_pkg::host_resp_s resp_o,
    output logic                    resp_v_o,
    input  logic                    resp_yumi_i
  );

  localparam int idx_w_lp = $clog2(`HOST_IO_MEM_WORDS);

  logic [`HOST_IO_DATA_W-1:0]    mem_r [`HOST_IO_MEM_WORDS];
  logic [idx_w_lp-1:0]           idx;
  logic                          is_rd;
  logic                          is_wr;

  logic                          req_v_r;
  host_io_pkg::host_cmd_header_s req_hdr_r;
  logic [`HOST_IO_DATA_W-1:0]    rd_data_r;
  logic                          req_rd_r;
  logic                          req_err_r;
  host_io_pkg::host_resp_s       resp_r;
  logic                          resp_v_r;

  // Doubleword index that wraps at the memory depth
  assign idx   = cmd_i.header.addr[3 +: idx_w_lp];
  assign is_rd = (cmd_i.header.opcode == host_io_pkg::e_host_rd);
  assign is_wr = (cmd_i.header.opcode == host_io_pkg::e_host_wr);

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      if (is_wr)
        mem_r[idx] <= cmd_i.data;
      rd_data_r <= mem_r[idx];
      req_hdr_r <= cmd_i.header;
      req_rd_r  <= is_rd;
      req_err_r <= ~(is_rd | is_wr);
    end
    if (req_v_r)
    begin
      resp_r.header <= req_hdr_r;
      resp_r.data   <= req_rd_r ? rd_data_r : '0;
      resp_r.err    <= req_err_r;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      req_v_r  <= 1'b0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      req_v_r <= cmd_v_i;
      if (req_v_r)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

  a_resp_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_yumi_i) |=> (resp_v_o && $stable(resp_o)));

endmodule

`default_nettype wire

//--- design/host_device.sv
/*
  Host device.
  Finish bits per core, trace enables, a putchar strobe and a
  read-only identity word, reached by offset in the device region.
  Register effects take place on the accepting edge and the response
  is registered one cycle later, held until yumi.
*/

`default_nettype none

`include "host_io_defines.svh"

module host_device
  #(
    parameter logic [`HOST_IO_DATA_W-1:0] dev_id_p = 64'h0000_0000_0b0a_5e01
  )
  (
    input  logic                          clk_i,
    input  logic                          reset_i,

    input  host_io_pkg::host_cmd_s        cmd_i,
    input  logic                          cmd_v_i,

    output host_io_pkg::host_resp_s       resp_o,
    output logic                          resp_v_o,
    input  logic                          resp_yumi_i,

    output logic [`HOST_IO_NUM_CORE-1:0]  finish_o,
    output logic [`HOST_IO_NUM_TRACE-1:0] trace_en_o,
    output logic [7:0]                    putch_o,
    output logic                          putch_v_o
  );

  logic [`HOST_IO_ADDR_W-1:0]   offset;
  logic                         is_rd;
  logic                         is_wr;
  logic                         hit_finish;
  logic                         hit_trace;
  logic                         hit_putch;
  logic                         hit_id;
  logic                         wr_ok;
  logic                         rd_ok;
  logic [`HOST_IO_DATA_W-1:0]   rd_data;

  logic [`HOST_IO_NUM_CORE-1:0]  finish_r;
  logic [`HOST_IO_NUM_TRACE-1:0] trace_r;
  logic [7:0]                    putch_r;
  logic                          putch_v_r;

  logic                          req_v_r;
  host_io_pkg::host_cmd_header_s req_hdr_r;
  logic [`HOST_IO_DATA_W-1:0]    req_data_r;
  logic                          req_err_r;
  host_io_pkg::host_resp_s       resp_r;
  logic                          resp_v_r;

  assign offset = cmd_i.header.addr & ~`HOST_IO_DEV_MASK;
  assign is_rd  = (cmd_i.header.opcode == host_io_pkg::e_host_rd);
  assign is_wr  = (cmd_i.header.opcode == host_io_pkg::e_host_wr);

  assign hit_finish = (offset == `HOST_IO_OFS_FINISH);
  assign hit_trace  = (offset == `HOST_IO_OFS_TRACE);
  assign hit_putch  = (offset == `HOST_IO_OFS_PUTCH);
  assign hit_id     = (offset == `HOST_IO_OFS_ID);

  // Identity is read-only
  assign wr_ok = is_wr & (hit_finish | hit_trace | hit_putch);
  assign rd_ok = is_rd & (hit_finish | hit_trace | hit_putch | hit_id);

  always_comb
  begin
    rd_data = '0;
    if (hit_finish)
      rd_data[`HOST_IO_NUM_CORE-1:0] = finish_r;
    else if (hit_trace)
      rd_data[`HOST_IO_NUM_TRACE-1:0] = trace_r;
    else if (hit_putch)
      rd_data[7:0] = putch_r;
    else if (hit_id)
      rd_data = dev_id_p;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      finish_r  <= '0;
      trace_r   <= '0;
      putch_v_r <= 1'b0;
    end
    else
    begin
      putch_v_r <= cmd_v_i & wr_ok & hit_putch;
      if (cmd_v_i && wr_ok && hit_finish)
        finish_r <= finish_r | cmd_i.data[`HOST_IO_NUM_CORE-1:0];
      if (cmd_v_i && wr_ok && hit_trace)
        trace_r <= cmd_i.data[`HOST_IO_NUM_TRACE-1:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i && wr_ok && hit_putch)
      putch_r <= cmd_i.data[7:0];
  end

  // Request stage
  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      req_hdr_r  <= cmd_i.header;
      req_data_r <= rd_ok ? rd_data : '0;
      req_err_r  <= ~(wr_ok | rd_ok);
    end
    if (req_v_r)
    begin
      resp_r.header <= req_hdr_r;
      resp_r.data   <= req_data_r;
      resp_r.err    <= req_err_r;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      req_v_r  <= 1'b0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      req_v_r <= cmd_v_i;
      if (req_v_r)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
    end
  end

  assign resp_o     = resp_r;
  assign resp_v_o   = resp_v_r;
  assign finish_o   = finish_r;
  assign trace_en_o = trace_r;
  assign putch_o    = putch_r;
  assign putch_v_o  = putch_v_r;

  a_no_cmd_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_r || req_v_r) |-> !cmd_v_i);

endmodule

`default_nettype wire

//--- design/host_addr_router.sv
/*
  Host address router.
  Steers each command to the host device or the backing memory by
  address, keeps one command in flight and returns the response of
  the chosen target to the master.
*/

`default_nettype none

`include "host_io_defines.svh"

module host_addr_router
  (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  host_io_pkg::host_cmd_s  cmd_i,
    input  logic                    cmd_v_i,
    output logic                    cmd_ready_o,

    output host_io_pkg::host_resp_s resp_o,
    output logic                    resp_v_o,
    input  logic                    resp_ready_i,

    output host_io_pkg::host_cmd_s  dev_cmd_o,
    output logic                    dev_cmd_v_o,
    input  host_io_pkg::host_resp_s dev_resp_i,
    input  logic                    dev_resp_v_i,
    output logic                    dev_resp_yumi_o,

    output host_io_pkg::host_cmd_s  mem_cmd_o,
    output logic                    mem_cmd_v_o,
    input  host_io_pkg::host_resp_s mem_resp_i,
    input  logic                    mem_resp_v_i,
    output logic                    mem_resp_yumi_o
  );

  logic pend_r;
  logic tgt_dev_r;
  logic sel_dev;
  logic cmd_acc;
  logic resp_done;

  assign sel_dev = ((cmd_i.header.addr & `HOST_IO_DEV_MASK) == `HOST_IO_DEV_BASE);

  // Only one command in flight
  assign cmd_ready_o = ~pend_r;
  assign cmd_acc     = cmd_v_i & cmd_ready_o;

  assign dev_cmd_o   = cmd_i;
  assign mem_cmd_o   = cmd_i;
  assign dev_cmd_v_o = cmd_acc & sel_dev;
  assign mem_cmd_v_o = cmd_acc & ~sel_dev;

  assign resp_o   = tgt_dev_r ? dev_resp_i : mem_resp_i;
  assign resp_v_o = pend_r & (tgt_dev_r ? dev_resp_v_i : mem_resp_v_i);

  assign resp_done       = resp_v_o & resp_ready_i;
  assign dev_resp_yumi_o = resp_done & tgt_dev_r;
  assign mem_resp_yumi_o = resp_done & ~tgt_dev_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pend_r    <= 1'b0;
      tgt_dev_r <= 1'b0;
    end
    else if (cmd_acc)
    begin
      pend_r    <= 1'b1;
      tgt_dev_r <= sel_dev;
    end
    else if (resp_done)
      pend_r <= 1'b0;
  end

  // The single-outstanding rule keeps the two targets from answering at once
  a_one_target_resp: assert property (@(posedge clk_i) disable iff (reset_i)
    !(dev_resp_v_i && mem_resp_v_i));

endmodule

`default_nettype wire

//--- design/host_io_pkg.sv
/*
  Host I/O package.
  Opcode encoding and the command and response formats
  carried on the processor-to-host ready-valid channel.
*/

`default_nettype none

`include "host_io_defines.svh"

package host_io_pkg;

  // 2'b11 is unassigned and treated like the reserved code
  typedef enum logic [1:0]
  {
    e_host_rd   = 2'b00,
    e_host_wr   = 2'b01,
    e_host_rsvd = 2'b10
  } host_opcode_e;

  typedef struct packed
  {
    host_opcode_e                opcode;
    logic [`HOST_IO_ADDR_W-1:0]  addr;
    // log2 of the access size in bytes
    logic [1:0]                  size;
  } host_cmd_header_s;

  typedef struct packed
  {
    host_cmd_header_s            header;
    logic [`HOST_IO_DATA_W-1:0]  data;
  } host_cmd_s;

  typedef struct packed
  {
    host_cmd_header_s            header;
    logic [`HOST_IO_DATA_W-1:0]  data;
    logic                        err;
  } host_resp_s;

endpackage

`default_nettype wire

//--- design/host_io_defines.svh
/*
  Host I/O subsystem constants.
  Bus widths, the address map of the host device region,
  the backing memory depth and the device register offsets.
*/

`ifndef HOST_IO_DEFINES_SVH
`define HOST_IO_DEFINES_SVH

`define HOST_IO_ADDR_W      32
`define HOST_IO_DATA_W      64

`define HOST_IO_NUM_CORE    4
// One enable per tracer or profiler kind
`define HOST_IO_NUM_TRACE   12

`define HOST_IO_DEV_BASE    32'h0010_0000
`define HOST_IO_DEV_MASK    32'hFFF0_0000

`define HOST_IO_MEM_WORDS   256

`define HOST_IO_OFS_FINISH  32'h0000_0000
`define HOST_IO_OFS_TRACE   32'h0000_0008
`define HOST_IO_OFS_PUTCH   32'h0000_0010
`define HOST_IO_OFS_ID      32'h0000_0018

`endif
